// File: hw/u712BusPkg.sv
package u712BusPkg;

    // CPU address lines seen by the bridge
    localparam int addrBits = 21;

    // 68040 SIZ1:SIZ0 encoding
    typedef enum logic [1:0] {
        sizeLong = 2'b00,
        sizeByte = 2'b01,
        sizeWord = 2'b10,
        sizeLine = 2'b11
    } sizeE;

    // Decoded target of one transfer
    typedef enum logic [1:0] {
        targetNone = 2'b00,
        targetReg  = 2'b01,
        targetRam  = 2'b10
    } targetE;

    // Attributes sampled with tsN
    typedef struct packed {
        logic                rnw;
        sizeE                siz;
        logic [addrBits-1:0] addr;
    } cpuReq;

    // Latched transfer, held until the CPU is acknowledged
    typedef struct packed {
        targetE              target;
        logic                rnw;
        sizeE                siz;
        logic [addrBits-1:0] addr;
    } cycleInfo;

endpackage

// File: hw/u712ChipPkg.sv
package u712ChipPkg;

    // 68000 style strobes toward Agnus and the custom chips
    // All active low
    typedef struct packed {
        logic asN;
        logic udsN;
        logic ldsN;
    } chipStrobes;

    // Strobes parked between register cycles
    localparam chipStrobes strobesIdle = '{
        asN:  1'b1,
        udsN: 1'b1,
        ldsN: 1'b1
    };

    // Chip RAM controls, bank is plain address bit 20
    typedef struct packed {
        logic ramEnN;
        logic rasN;
        logic casN;
        logic weN;
        logic bank;
    } ramCtrl;

    // RAM controls parked between cycles
    localparam ramCtrl ramIdle = '{
        ramEnN: 1'b1,
        rasN:   1'b1,
        casN:   1'b1,
        weN:    1'b1,
        bank:   1'b0
    };

endpackage

// File: hw/u712CycleDecode.sv
`timescale 1ns/1ps

module u712CycleDecode (
    input  logic                  CLK40,
    input  logic                  rstN,
    input  logic                  tsN,
    input  logic                  regSpaceN,
    input  logic                  ramSpaceN,
    input  u712BusPkg::cpuReq     req,
    input  logic                  done,
    output u712BusPkg::cycleInfo  info,
    output logic                  cycleActive,
    output logic                  vbEnN,
    output logic                  dbDir
);

    // Target seen in the tsN cycle
    u712BusPkg::targetE targetNext;

    // Register space wins over RAM space
    always_comb begin
        if (!regSpaceN) begin
            targetNext = u712BusPkg::targetReg;
        end else if (!ramSpaceN) begin
            targetNext = u712BusPkg::targetRam;
        end else begin
            targetNext = u712BusPkg::targetNone;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Transfer record
    //////////////////////////////////////////////////////////////////////

    // Captured once per transfer
    always_ff @(posedge CLK40) begin
        if (!tsN) begin
            info.target <= targetNext;
            info.rnw    <= req.rnw;
            info.siz    <= req.siz;
            info.addr   <= req.addr;
        end
    end

    // Open from the cycle after tsN, closed the cycle after done
    always_ff @(posedge CLK40 or negedge rstN) begin
        if (!rstN) begin
            cycleActive <= 1'b0;
        end else if (!tsN) begin
            cycleActive <= 1'b1;
        end else if (done) begin
            cycleActive <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Chipset data buffers
    //////////////////////////////////////////////////////////////////////

    // Buffer only opened for register cycles
    assign vbEnN = ~(cycleActive && (info.target == u712BusPkg::targetReg));
    // High drives CPU data toward the chipset
    assign dbDir = cycleActive & ~info.rnw;

endmodule

// File: hw/u712ByteEnable.sv
`timescale 1ns/1ps

module u712ByteEnable (
    input  u712BusPkg::cycleInfo info,
    output logic [3:0]           laneEnN,
    output logic                 udsN,
    output logic                 ldsN
);

    // Active high lane select
    // Bit 3 is lane 0, the D31:24 byte
    logic [3:0] laneOn;

    always_comb begin
        case (info.siz)
            u712BusPkg::sizeByte: begin
                // Single lane picked by A1:A0
                laneOn = 4'b1000 >> info.addr[1:0];
            end
            u712BusPkg::sizeWord: begin
                // Upper or lower half by A1
                if (info.addr[1]) begin
                    laneOn = 4'b0011;
                end else begin
                    laneOn = 4'b1100;
                end
            end
            default: begin
                // Long and line use the whole bus
                laneOn = 4'b1111;
            end
        endcase
    end

    assign laneEnN = ~laneOn;

    // Even lanes on D15:8 of the 68000 side
    assign udsN = ~(laneOn[3] | laneOn[1]);
    // Odd lanes on D7:0
    assign ldsN = ~(laneOn[2] | laneOn[0]);

endmodule

// File: hw/u712ChipRegCycle.sv
`timescale 1ns/1ps

module u712ChipRegCycle (
    input  logic                    CLK40,
    input  logic                    rstN,
    input  u712BusPkg::cycleInfo    info,
    input  logic                    cycleActive,
    input  logic                    c1,
    input  logic                    dbrN,
    input  logic                    udsN,
    input  logic                    ldsN,
    output u712ChipPkg::chipStrobes strobes,
    output logic                    regAck
);

    // Skew only used by writes
    typedef enum logic [1:0] {
        stIdle,
        stSkew,
        stWait,
        stDone
    } regStateE;

    regStateE state;
    logic     c1Prev;
    logic     c1Rise;
    logic     regStart;

    // C1 edge as seen by CLK40
    assign c1Rise   = c1 & ~c1Prev;
    assign regStart = cycleActive && (info.target == u712BusPkg::targetReg);

    always_ff @(posedge CLK40 or negedge rstN) begin
        if (!rstN) begin
            // Parked high so release from reset is no edge
            c1Prev  <= 1'b1;
            state   <= stIdle;
            strobes <= u712ChipPkg::strobesIdle;
            regAck  <= 1'b0;
        end else begin
            c1Prev <= c1;
            regAck <= 1'b0;
            case (state)
                stIdle: begin
                    if (regStart && c1Rise) begin
                        strobes.asN <= 1'b0;
                        // Reads drop data strobes with asN
                        if (info.rnw) begin
                            strobes.udsN <= udsN;
                            strobes.ldsN <= ldsN;
                            state        <= stWait;
                        end else begin
                            state <= stSkew;
                        end
                    end
                end
                stSkew: begin
                    // Write data strobes one clock late
                    strobes.udsN <= udsN;
                    strobes.ldsN <= ldsN;
                    state        <= stWait;
                end
                stWait: begin
                    // Agnus holds us off with dbrN
                    if (c1Rise && dbrN) begin
                        strobes <= u712ChipPkg::strobesIdle;
                        regAck  <= 1'b1;
                        state   <= stDone;
                    end
                end
                stDone: begin
                    // No restart before the CPU cycle closes
                    if (!cycleActive) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// File: hw/u712ChipRamCycle.sv
`timescale 1ns/1ps

module u712ChipRamCycle #(
    parameter int rasToCas  = 2,
    parameter int casCycles = 2
) (
    input  logic                 CLK40,
    input  logic                 rstN,
    input  u712BusPkg::cycleInfo info,
    input  logic                 cycleActive,
    input  logic [1:0]           agnusRasN,
    output u712ChipPkg::ramCtrl  ram,
    output logic                 ramAck
);

    localparam int totalCycles = rasToCas + casCycles;
    localparam int cntBits     = $clog2(totalCycles + 1);

    typedef enum logic [1:0] {
        stIdle,
        stRun,
        stDone
    } ramStateE;

    ramStateE           state;
    // Index of the RAS cycle now on the pins
    logic [cntBits-1:0] cnt;
    logic               ramStart;
    logic               agnusFree;

    assign agnusFree = &agnusRasN;
    assign ramStart  = cycleActive && (info.target == u712BusPkg::targetRam);

    always_ff @(posedge CLK40 or negedge rstN) begin
        if (!rstN) begin
            state  <= stIdle;
            cnt    <= '0;
            ram    <= u712ChipPkg::ramIdle;
            ramAck <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    // Arbitration only here, never mid sequence
                    if (ramStart && agnusFree) begin
                        ram.ramEnN <= 1'b0;
                        ram.rasN   <= 1'b0;
                        ram.weN    <= info.rnw;
                        ram.bank   <= info.addr[u712BusPkg::addrBits-1];
                        cnt        <= '0;
                        state      <= stRun;
                    end
                end
                stRun: begin
                    cnt <= cnt + 1'b1;
                    // CAS for the trailing casCycles
                    if (cnt == cntBits'(rasToCas - 1)) begin
                        ram.casN <= 1'b0;
                    end
                    // Ack lands on the last CAS cycle
                    ramAck <= (cnt == cntBits'(totalCycles - 2));
                    if (cnt == cntBits'(totalCycles - 1)) begin
                        ram   <= u712ChipPkg::ramIdle;
                        state <= stDone;
                    end
                end
                stDone: begin
                    ramAck <= 1'b0;
                    if (!cycleActive) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// File: hw/u712TransferAck.sv
`timescale 1ns/1ps

module u712TransferAck #(
    parameter int timeoutCycles = 64
) (
    input  logic                 CLK40,
    input  logic                 rstN,
    input  u712BusPkg::cycleInfo info,
    input  logic                 cycleActive,
    input  logic                 regAck,
    input  logic                 ramAck,
    output logic                 taN,
    output logic                 teaN,
    output logic                 tbiN,
    output logic                 done
);

    localparam int wdBits = $clog2(timeoutCycles + 1);

    logic [wdBits-1:0] wdCnt;
    logic              ended;
    logic              ackIn;
    logic              expired;

    // Only the block that owns the target may end it
    assign ackIn = ((info.target == u712BusPkg::targetReg) && regAck) ||
                   ((info.target == u712BusPkg::targetRam) && ramAck);
    assign expired = (wdCnt == wdBits'(timeoutCycles - 1));

    always_ff @(posedge CLK40 or negedge rstN) begin
        if (!rstN) begin
            taN   <= 1'b1;
            teaN  <= 1'b1;
            tbiN  <= 1'b1;
            done  <= 1'b0;
            wdCnt <= '0;
            ended <= 1'b0;
        end else begin
            taN  <= 1'b1;
            teaN <= 1'b1;
            tbiN <= 1'b1;
            done <= 1'b0;
            if (!cycleActive) begin
                wdCnt <= '0;
                ended <= 1'b0;
            end else if (!ended) begin
                wdCnt <= wdCnt + 1'b1;
                if (ackIn) begin
                    // Lines cannot burst on chipset space
                    taN   <= 1'b0;
                    tbiN  <= ~(info.siz == u712BusPkg::sizeLine);
                    done  <= 1'b1;
                    ended <= 1'b1;
                end else if (expired) begin
                    // Silent cycle, bus error to the CPU
                    teaN  <= 1'b0;
                    done  <= 1'b1;
                    ended <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/u712Top.sv
`timescale 1ns/1ps

module u712Top #(
    parameter int rasToCas      = 2,
    parameter int casCycles     = 2,
    parameter int timeoutCycles = 64
) (
    input  logic                    CLK40,
    input  logic                    rstN,
    input  logic                    tsN,
    input  u712BusPkg::cpuReq       req,
    input  logic                    regSpaceN,
    input  logic                    ramSpaceN,
    input  logic                    c1,
    input  logic                    dbrN,
    input  logic [1:0]              agnusRasN,
    output logic [3:0]              laneEnN,
    output u712ChipPkg::chipStrobes strobes,
    output u712ChipPkg::ramCtrl     ram,
    output logic                    vbEnN,
    output logic                    dbDir,
    output logic                    taN,
    output logic                    teaN,
    output logic                    tbiN
);

    u712BusPkg::cycleInfo info;
    logic                 cycleActive;
    logic                 done;
    logic [3:0]           laneDecN;
    logic                 udsN;
    logic                 ldsN;
    logic                 regAck;
    logic                 ramAck;

    //////////////////////////////////////////////////////////////////////
    // Transfer start and byte lanes
    //////////////////////////////////////////////////////////////////////

    u712CycleDecode u_cycleDecode (
        .CLK40       (CLK40),
        .rstN        (rstN),
        .tsN         (tsN),
        .regSpaceN   (regSpaceN),
        .ramSpaceN   (ramSpaceN),
        .req         (req),
        .done        (done),
        .info        (info),
        .cycleActive (cycleActive),
        .vbEnN       (vbEnN),
        .dbDir       (dbDir)
    );

    u712ByteEnable u_byteEnable (
        .info    (info),
        .laneEnN (laneDecN),
        .udsN    (udsN),
        .ldsN    (ldsN)
    );

    // Lanes idle between transfers
    assign laneEnN = laneDecN | {4{~cycleActive}};

    //////////////////////////////////////////////////////////////////////
    // Chipset cycles and CPU acknowledge
    //////////////////////////////////////////////////////////////////////

    u712ChipRegCycle u_chipRegCycle (
        .CLK40       (CLK40),
        .rstN        (rstN),
        .info        (info),
        .cycleActive (cycleActive),
        .c1          (c1),
        .dbrN        (dbrN),
        .udsN        (udsN),
        .ldsN        (ldsN),
        .strobes     (strobes),
        .regAck      (regAck)
    );

    u712ChipRamCycle #(
        .rasToCas  (rasToCas),
        .casCycles (casCycles)
    ) u_chipRamCycle (
        .CLK40       (CLK40),
        .rstN        (rstN),
        .info        (info),
        .cycleActive (cycleActive),
        .agnusRasN   (agnusRasN),
        .ram         (ram),
        .ramAck      (ramAck)
    );

    u712TransferAck #(
        .timeoutCycles (timeoutCycles)
    ) u_transferAck (
        .CLK40       (CLK40),
        .rstN        (rstN),
        .info        (info),
        .cycleActive (cycleActive),
        .regAck      (regAck),
        .ramAck      (ramAck),
        .taN         (taN),
        .teaN        (teaN),
        .tbiN        (tbiN),
        .done        (done)
    );

endmodule

// File: verification/u712Model.svh
// Cycle model of the bridge, stepped once per CLK40 edge

// Phase numbers for the two chipset sequences
localparam int phIdle = 0;
localparam int phSkew = 1;
localparam int phWait = 2;
localparam int phRun  = 3;
localparam int phDone = 4;

// Open transfer and CPU acknowledge
logic                    mActive;
u712BusPkg::cycleInfo    mInfo;
logic                    mDone;
logic                    mTaN;
logic                    mTeaN;
logic                    mTbiN;
int                      mWatch;
logic                    mEnded;
// Register strobe sequence
u712ChipPkg::chipStrobes mStrobes;
logic                    mRegAck;
int                      mRegPhase;
logic                    mC1Prev;
logic                    mC1Rise;
// Chip RAM sequence
u712ChipPkg::ramCtrl     mRam;
logic                    mRamAck;
int                      mRamPhase;
int                      mRasCount;

// Bit n set when CPU lane n carries data, lane 0 is D31:24
function automatic logic [3:0] laneMask(input u712BusPkg::sizeE siz, input logic [1:0] a);
    logic [3:0] m;
    int         lane;
    for (lane = 0; lane < 4; lane++) begin
        if (siz == u712BusPkg::sizeByte) begin
            m[lane] = (lane == int'(a));
        end else if (siz == u712BusPkg::sizeWord) begin
            // Word covers one half of the bus
            m[lane] = ((lane / 2) == int'(a[1]));
        end else begin
            m[lane] = 1'b1;
        end
    end
    return m;
endfunction

task automatic compareValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
        errorCount++;
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp,
                 cycleCount);
    end
endtask

task automatic resetModel();
    mActive   = 1'b0;
    mInfo     = '0;
    mDone     = 1'b0;
    mTaN      = 1'b1;
    mTeaN     = 1'b1;
    mTbiN     = 1'b1;
    mWatch    = 0;
    mEnded    = 1'b0;
    mStrobes  = '1;
    mRegAck   = 1'b0;
    mRegPhase = phIdle;
    // No c1 edge seen on the first sample
    mC1Prev   = 1'b1;
    mC1Rise   = 1'b0;
    mRam      = '{ramEnN: 1'b1, rasN: 1'b1, casN: 1'b1, weN: 1'b1, bank: 1'b0};
    mRamAck   = 1'b0;
    mRamPhase = phIdle;
    mRasCount = 0;
endtask

task automatic advanceModel();
    logic                 wasActive;
    u712BusPkg::cycleInfo was;
    logic                 wasDone;
    logic                 wasRegAck;
    logic                 wasRamAck;
    logic [3:0]           lanes;
    logic                 ackSeen;
    if (!rstN) begin
        resetModel();
    end else begin
        // Every block sees the state from before this edge
        wasActive = mActive;
        was       = mInfo;
        wasDone   = mDone;
        wasRegAck = mRegAck;
        wasRamAck = mRamAck;
        lanes     = laneMask(was.siz, was.addr[1:0]);
        mC1Rise   = c1 && !mC1Prev;
        mC1Prev   = c1;

        ////////////////////////////////////////////////////////////////////
        // Start strobe and acknowledge
        ////////////////////////////////////////////////////////////////////

        if (!tsN) begin
            mActive    = 1'b1;
            mInfo.rnw  = req.rnw;
            mInfo.siz  = req.siz;
            mInfo.addr = req.addr;
            // Register space has priority
            if (!regSpaceN) begin
                mInfo.target = u712BusPkg::targetReg;
            end else if (!ramSpaceN) begin
                mInfo.target = u712BusPkg::targetRam;
            end else begin
                mInfo.target = u712BusPkg::targetNone;
            end
        end else if (wasDone) begin
            mActive = 1'b0;
        end

        mTaN  = 1'b1;
        mTeaN = 1'b1;
        mTbiN = 1'b1;
        mDone = 1'b0;
        if (!wasActive) begin
            mWatch = 0;
            mEnded = 1'b0;
        end else if (!mEnded) begin
            mWatch++;
            ackSeen = ((was.target == u712BusPkg::targetReg) && wasRegAck) ||
                      ((was.target == u712BusPkg::targetRam) && wasRamAck);
            if (ackSeen) begin
                mTaN   = 1'b0;
                mTbiN  = (was.siz != u712BusPkg::sizeLine);
                mDone  = 1'b1;
                mEnded = 1'b1;
            end else if (mWatch == timeoutCycles) begin
                mTeaN  = 1'b0;
                mDone  = 1'b1;
                mEnded = 1'b1;
            end
        end

        ////////////////////////////////////////////////////////////////////
        // Chipset sequences
        ////////////////////////////////////////////////////////////////////

        mRegAck = 1'b0;
        case (mRegPhase)
            phIdle: begin
                if (wasActive && was.target == u712BusPkg::targetReg && mC1Rise) begin
                    mStrobes.asN = 1'b0;
                    if (was.rnw) begin
                        mStrobes.udsN = !(lanes[0] || lanes[2]);
                        mStrobes.ldsN = !(lanes[1] || lanes[3]);
                        mRegPhase     = phWait;
                    end else begin
                        mRegPhase = phSkew;
                    end
                end
            end
            phSkew: begin
                mStrobes.udsN = !(lanes[0] || lanes[2]);
                mStrobes.ldsN = !(lanes[1] || lanes[3]);
                mRegPhase     = phWait;
            end
            phWait: begin
                if (mC1Rise && dbrN) begin
                    mStrobes  = '1;
                    mRegAck   = 1'b1;
                    mRegPhase = phDone;
                end
            end
            default: begin
                if (!wasActive) begin
                    mRegPhase = phIdle;
                end
            end
        endcase

        mRamAck = 1'b0;
        case (mRamPhase)
            phIdle: begin
                if (wasActive && was.target == u712BusPkg::targetRam && agnusRasN == 2'b11) begin
                    mRam.ramEnN = 1'b0;
                    mRam.rasN   = 1'b0;
                    mRam.weN    = was.rnw;
                    mRam.bank   = was.addr[20];
                    mRasCount   = 1;
                    mRamPhase   = phRun;
                end
            end
            phRun: begin
                if (mRasCount == rasToCas + casCycles) begin
                    mRam      = '{ramEnN: 1'b1, rasN: 1'b1, casN: 1'b1, weN: 1'b1, bank: 1'b0};
                    mRamPhase = phDone;
                end else begin
                    mRasCount++;
                    // CAS over the trailing cycles, ack on the last one
                    if (mRasCount > rasToCas) begin
                        mRam.casN = 1'b0;
                    end
                    mRamAck = (mRasCount == rasToCas + casCycles);
                end
            end
            default: begin
                if (!wasActive) begin
                    mRamPhase = phIdle;
                end
            end
        endcase
    end
endtask

// File: verification/u712Tb.sv
`timescale 1ns/1ps

module u712Tb;

    localparam int rasToCas      = 2;
    localparam int casCycles     = 2;
    localparam int timeoutCycles = 64;
    localparam int numTransfers  = 200;
    // Longest transfer is the watchdog plus the idle gap
    localparam int cycleLimit    = numTransfers * 70 + 100;

    logic                    CLK40;
    logic                    rstN;
    logic                    tsN;
    u712BusPkg::cpuReq       req;
    logic                    regSpaceN;
    logic                    ramSpaceN;
    logic                    c1;
    logic                    dbrN;
    logic [1:0]              agnusRasN;
    logic [3:0]              laneEnN;
    u712ChipPkg::chipStrobes strobes;
    u712ChipPkg::ramCtrl     ram;
    logic                    vbEnN;
    logic                    dbDir;
    logic                    taN;
    logic                    teaN;
    logic                    tbiN;

    integer                  seed;
    int                      errorCount;
    int                      checkCount;
    int                      cycleCount;
    int                      sent;
    // Chipset side activity
    int                      c1Count;
    int                      dbrLeft;
    int                      agnusLeft;
    logic [1:0]              agnusHold;
    // Transfer in progress
    u712BusPkg::targetE      kind;
    int                      startCycle;
    int                      rasFallCycle;
    u712ChipPkg::chipStrobes strobesPrev;
    u712ChipPkg::ramCtrl     ramPrev;

    `include "u712Model.svh"

    u712Top #(
        .rasToCas      (rasToCas),
        .casCycles     (casCycles),
        .timeoutCycles (timeoutCycles)
    ) u_u712Top (
        .CLK40     (CLK40),
        .rstN      (rstN),
        .tsN       (tsN),
        .req       (req),
        .regSpaceN (regSpaceN),
        .ramSpaceN (ramSpaceN),
        .c1        (c1),
        .dbrN      (dbrN),
        .agnusRasN (agnusRasN),
        .laneEnN   (laneEnN),
        .strobes   (strobes),
        .ram       (ram),
        .vbEnN     (vbEnN),
        .dbDir     (dbDir),
        .taN       (taN),
        .teaN      (teaN),
        .tbiN      (tbiN)
    );

    initial begin
        CLK40 = 1'b0;
        forever #50 CLK40 = ~CLK40;
    end

    function automatic logic [31:0] randomWord();
        return $random(seed);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Chipset behavior
    //////////////////////////////////////////////////////////////////////

    task automatic driveChipset();
        logic [31:0] raw;
        raw = randomWord();
        // C1 phase with a 12 cycle period
        c1Count++;
        if (c1Count == 6) begin
            c1      = ~c1;
            c1Count = 0;
        end
        // Low runs of 1 to 4 cycles split by at least one high cycle
        if (dbrLeft > 0) begin
            dbrN = 1'b0;
            dbrLeft--;
        end else if (dbrN && raw[10:8] == 3'd0) begin
            dbrN    = 1'b0;
            dbrLeft = int'(raw[12:11]);
        end else begin
            dbrN = 1'b1;
        end
        if (agnusLeft > 0) begin
            agnusRasN = agnusHold;
            agnusLeft--;
        end else if (agnusRasN == 2'b11 && raw[1:0] == 2'd0) begin
            agnusHold = (raw[3:2] == 2'd0) ? 2'b00 : (raw[2] ? 2'b01 : 2'b10);
            agnusRasN = agnusHold;
            agnusLeft = int'(raw[5:4]);
        end else begin
            agnusRasN = 2'b11;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Per cycle checks
    //////////////////////////////////////////////////////////////////////

    task automatic checkOutputs();
        logic [3:0] mask;
        logic [3:0] lanesExp;
        mask     = laneMask(mInfo.siz, mInfo.addr[1:0]);
        lanesExp = mActive ? ~{mask[0], mask[1], mask[2], mask[3]} : 4'hF;
        compareValue("laneEnN", 32'(laneEnN), 32'(lanesExp));
        compareValue("strobes", 32'(strobes), 32'(mStrobes));
        compareValue("ram", 32'(ram), 32'(mRam));
        compareValue("vbEnN", 32'(vbEnN),
                     32'(!(mActive && mInfo.target == u712BusPkg::targetReg)));
        compareValue("dbDir", 32'(dbDir), 32'(mActive && !mInfo.rnw));
        compareValue("taN", 32'(taN), 32'(mTaN));
        compareValue("teaN", 32'(teaN), 32'(mTeaN));
        compareValue("tbiN", 32'(tbiN), 32'(mTbiN));
        if (strobesPrev.asN && !strobes.asN && !mC1Rise) begin
            errorCount++;
            $display("asN fell at cycle %0d without a c1 rising edge", cycleCount);
        end
        if (ramPrev.rasN && !ram.rasN) begin
            rasFallCycle = cycleCount;
            if (agnusRasN != 2'b11) begin
                errorCount++;
                $display("rasN fell at cycle %0d while Agnus owned chip RAM", cycleCount);
            end
        end
        if (!taN && kind == u712BusPkg::targetRam) begin
            compareValue("rasN to taN cycles", cycleCount - rasFallCycle, rasToCas + casCycles);
        end
        if (!teaN && kind == u712BusPkg::targetNone) begin
            compareValue("tsN to teaN cycles", cycleCount - startCycle, timeoutCycles);
        end
        strobesPrev = strobes;
        ramPrev     = ram;
    endtask

    // Edge, model step, checks, then new chipset inputs 1 ns later
    task automatic nextCycle();
        @(posedge CLK40);
        advanceModel();
        cycleCount++;
        #1;
        checkOutputs();
        driveChipset();
    endtask

    task automatic sendTransfer();
        logic [31:0] raw;
        logic [31:0] addrRaw;
        int          pick;
        logic        ended;
        raw      = randomWord();
        pick     = int'(raw[31:16] % 16'd20);
        req.rnw  = raw[0];
        addrRaw  = randomWord();
        req.addr = addrRaw[u712BusPkg::addrBits-1:0];
        if (pick < 2) begin
            // Unmapped so only the watchdog ends it
            kind      = u712BusPkg::targetNone;
            regSpaceN = 1'b1;
            ramSpaceN = 1'b1;
            req.siz   = u712BusPkg::sizeE'(raw[2:1]);
        end else if (pick < 11) begin
            kind      = u712BusPkg::targetReg;
            regSpaceN = 1'b0;
            ramSpaceN = raw[3];
            req.siz   = raw[1] ? u712BusPkg::sizeByte : u712BusPkg::sizeWord;
        end else begin
            kind      = u712BusPkg::targetRam;
            regSpaceN = 1'b1;
            ramSpaceN = 1'b0;
            req.siz   = u712BusPkg::sizeE'(raw[2:1]);
        end
        tsN = 1'b0;
        nextCycle();
        startCycle = cycleCount;
        // Attributes are junk outside the start strobe
        tsN       = 1'b1;
        regSpaceN = 1'b1;
        ramSpaceN = 1'b1;
        raw       = randomWord();
        req       = raw[$bits(req)-1:0];
        ended     = 1'b0;
        while (!ended) begin
            nextCycle();
            ended = !taN || !teaN;
        end
        sent++;
        // CPU idles at least one cycle before the next start
        repeat (1 + int'(randomWord() & 32'h3)) nextCycle();
    endtask

    initial begin
        seed         = 82;
        errorCount   = 0;
        checkCount   = 0;
        cycleCount   = 0;
        sent         = 0;
        rstN         = 1'b0;
        tsN          = 1'b1;
        req          = '0;
        regSpaceN    = 1'b1;
        ramSpaceN    = 1'b1;
        c1           = 1'b0;
        dbrN         = 1'b1;
        agnusRasN    = 2'b11;
        c1Count      = 0;
        dbrLeft      = 0;
        agnusLeft    = 0;
        agnusHold    = 2'b11;
        kind         = u712BusPkg::targetNone;
        startCycle   = 0;
        rasFallCycle = 0;
        strobesPrev  = '1;
        ramPrev      = '1;
        resetModel();
        repeat (8) nextCycle();
        rstN = 1'b1;
        // Outputs stay parked until the first start strobe
        repeat (4) nextCycle();
        while (sent < numTransfers) begin
            sendTransfer();
        end
        $display("Summary: %0d transfers, %0d checks, %0d errors", sent, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Run limit
    initial begin
        wait (cycleCount >= cycleLimit);
        $display("Run hung: transfer %0d still open after %0d cycles", sent, cycleCount);
        $display("Summary: %0d transfers, %0d checks, %0d errors", sent, checkCount, errorCount);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: project.f
+incdir+verification
hw/u712BusPkg.sv
hw/u712ChipPkg.sv
hw/u712CycleDecode.sv
hw/u712ByteEnable.sv
hw/u712ChipRegCycle.sv
hw/u712ChipRamCycle.sv
hw/u712TransferAck.sv
hw/u712Top.sv
verification/u712Tb.sv

// File: Bender.yml
package:
  name: u712_bridge

sources:
  - files:
      - hw/u712BusPkg.sv
      - hw/u712ChipPkg.sv
      - hw/u712CycleDecode.sv
      - hw/u712ByteEnable.sv
      - hw/u712ChipRegCycle.sv
      - hw/u712ChipRamCycle.sv
      - hw/u712TransferAck.sv
      - hw/u712Top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/u712Tb.sv
